// ==== verilog/axis_pkg.sv ====
// stream-side constants and beat types
// shared by the datapath defaults and the testbench
package axis_pkg;

    // default datapath width in bits
    localparam int AXIS_DATA_WIDTH = 64;

    // one byte enable per data byte
    localparam int AXIS_KEEP_WIDTH = AXIS_DATA_WIDTH / 8;

    // one data beat at the default width
    typedef logic [AXIS_DATA_WIDTH-1:0] axis_data_t;

    // byte enables for one beat
    typedef logic [AXIS_KEEP_WIDTH-1:0] axis_keep_t;

endpackage

// ==== verilog/rate_pkg.sv ====
// rate control types and config register map
package rate_pkg;

    // one rate term, used for both numerator and denominator
    typedef logic [7:0] rate_t;

    // credit accumulator, wide enough for long bursts of debt
    typedef logic [23:0] rate_acc_t;

    // config register address
    typedef logic [1:0] cfg_addr_t;

    // register map
    localparam cfg_addr_t CFG_ADDR_NUM   = 2'd0;
    localparam cfg_addr_t CFG_ADDR_DENOM = 2'd1;
    localparam cfg_addr_t CFG_ADDR_MODE  = 2'd2;

    // 1/1 after reset, so the limiter starts at full rate
    localparam rate_t RATE_NUM_RST   = 8'd1;
    localparam rate_t RATE_DENOM_RST = 8'd1;

endpackage

// ==== verilog/axis_if.sv ====
`timescale 1ns/1ps

// AXI4-Stream link between two blocks inside the design
interface axis_if #(
    parameter int DATA_WIDTH = axis_pkg::AXIS_DATA_WIDTH
);

    // one byte enable per data byte
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    logic                  tuser;

    // upstream side, drives the beat and waits for tready
    modport source (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    // downstream side, only tready flows back
    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

// ==== verilog/rate_cfg_regs.sv ====
`timescale 1ns/1ps

// rate settings register block
// plain strobe write, combinational readback
module rate_cfg_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_we,
    input  rate_pkg::cfg_addr_t cfg_addr,
    input  rate_pkg::rate_t     cfg_wdata,
    output rate_pkg::rate_t     cfg_rdata,
    output rate_pkg::rate_t     rate_num,
    output rate_pkg::rate_t     rate_denom,
    output logic                rate_by_frame
);

    import rate_pkg::*;

    rate_t num_reg;
    rate_t denom_reg;
    logic  by_frame_reg;

    // write decode, effective from the next edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num_reg      <= RATE_NUM_RST;
            denom_reg    <= RATE_DENOM_RST;
            by_frame_reg <= 1'b0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_ADDR_NUM:   num_reg      <= cfg_wdata;
                CFG_ADDR_DENOM: denom_reg    <= cfg_wdata;
                // mode flag lives in bit 0
                CFG_ADDR_MODE:  by_frame_reg <= cfg_wdata[0];
                // unmapped address, write dropped
                default: ;
            endcase
        end
    end

    // readback mux, unmapped reads as zero
    always_comb begin
        case (cfg_addr)
            CFG_ADDR_NUM:   cfg_rdata = num_reg;
            CFG_ADDR_DENOM: cfg_rdata = denom_reg;
            CFG_ADDR_MODE:  cfg_rdata = rate_t'(by_frame_reg);
            default:        cfg_rdata = '0;
        endcase
    end

    assign rate_num      = num_reg;
    assign rate_denom    = denom_reg;
    assign rate_by_frame = by_frame_reg;

endmodule

// ==== verilog/axis_rate_limit.sv ====
`timescale 1ns/1ps

// credit based rate limiter
// accepts on average rate_num beats every rate_denom cycles
module axis_rate_limit #(
    parameter int  DATA_WIDTH = axis_pkg::AXIS_DATA_WIDTH,
    localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  rst,

    // input stream
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic [KEEP_WIDTH-1:0] s_tkeep,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  logic                  s_tlast,
    input  logic                  s_tuser,

    // toward the skid register
    axis_if.source                m,
    input  logic                  ready_early,

    // rate settings
    input  rate_pkg::rate_t       rate_num,
    input  rate_pkg::rate_t       rate_denom,
    input  logic                  rate_by_frame
);

    import rate_pkg::*;

    rate_acc_t acc_reg;
    rate_acc_t acc_next;
    rate_acc_t num_ext;
    rate_acc_t denom_ext;
    logic      frame_reg;
    logic      frame_next;
    logic      pause;
    logic      s_tready_reg;
    logic      s_tready_next;
    logic      xfer;

    assign num_ext   = rate_acc_t'(rate_num);
    assign denom_ext = rate_acc_t'(rate_denom);

    // beats pass straight through, valid only while our ready is up
    assign m.tdata  = s_tdata;
    assign m.tkeep  = s_tkeep;
    assign m.tvalid = s_tvalid & s_tready_reg;
    assign m.tlast  = s_tlast;
    assign m.tuser  = s_tuser;

    assign s_tready = s_tready_reg;

    // a beat really moves only on the link handshake
    assign xfer = m.tvalid & m.tready;

    always_comb begin
        acc_next   = acc_reg;
        frame_next = frame_reg;
        pause      = 1'b0;

        if (xfer) begin
            // each beat costs denom - num credits of debt
            acc_next   = acc_reg + denom_ext - num_ext;
            // a beat without tlast opens or continues a frame
            frame_next = ~s_tlast;
        end else if (acc_reg >= num_ext) begin
            // idle cycle pays num back
            acc_next = acc_reg - num_ext;
        end

        // too much debt, hold off
        // in frame mode only between frames
        if (acc_next >= num_ext) begin
            pause = rate_by_frame ? ~frame_next : 1'b1;
        end

        s_tready_next = ready_early & ~pause;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_reg      <= '0;
            frame_reg    <= 1'b0;
            s_tready_reg <= 1'b0;
        end else begin
            acc_reg      <= acc_next;
            frame_reg    <= frame_next;
            // ready shows up one cycle after the decision
            s_tready_reg <= s_tready_next;
        end
    end

endmodule

// ==== verilog/axis_skid_reg.sv ====
`timescale 1ns/1ps

// two-entry output register with main and temp entries
// all outputs registered with full throughput under back-pressure
module axis_skid_reg #(
    parameter int  DATA_WIDTH = axis_pkg::AXIS_DATA_WIDTH,
    localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  rst,

    // from the limiter
    axis_if.sink                  s,
    output logic                  ready_early,

    // output stream
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic [KEEP_WIDTH-1:0] m_tkeep,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output logic                  m_tlast,
    output logic                  m_tuser
);

    // main register drives the outputs
    logic [DATA_WIDTH-1:0] main_tdata;
    logic [KEEP_WIDTH-1:0] main_tkeep;
    logic                  main_tvalid;
    logic                  main_tlast;
    logic                  main_tuser;

    // temp register catches a beat while the sink stalls
    logic [DATA_WIDTH-1:0] temp_tdata;
    logic [KEEP_WIDTH-1:0] temp_tkeep;
    logic                  temp_tvalid;
    logic                  temp_tlast;
    logic                  temp_tuser;

    // delayed ready_early as the limiter currently sees it
    logic ready_reg;

    assign s.tready = ready_reg;

    // open next cycle if sink drains, both empty,
    // or temp empty and nothing lands in it now
    assign ready_early = m_tready | (~temp_tvalid & ~main_tvalid) | (~temp_tvalid & ~s.tvalid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg   <= 1'b0;
            main_tvalid <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (ready_reg) begin
                if (m_tready | ~main_tvalid) begin
                    // main free or draining so load it directly
                    main_tvalid <= s.tvalid;
                end else begin
                    // sink stalled so park the beat in temp
                    temp_tvalid <= s.tvalid;
                end
            end else if (m_tready) begin
                // input closed so move temp up
                main_tvalid <= temp_tvalid;
                temp_tvalid <= 1'b0;
            end
        end
    end

    // payload follows the same steering
    always_ff @(posedge clk) begin
        if (ready_reg) begin
            if (m_tready | ~main_tvalid) begin
                main_tdata <= s.tdata;
                main_tkeep <= s.tkeep;
                main_tlast <= s.tlast;
                main_tuser <= s.tuser;
            end else begin
                temp_tdata <= s.tdata;
                temp_tkeep <= s.tkeep;
                temp_tlast <= s.tlast;
                temp_tuser <= s.tuser;
            end
        end else if (m_tready) begin
            main_tdata <= temp_tdata;
            main_tkeep <= temp_tkeep;
            main_tlast <= temp_tlast;
            main_tuser <= temp_tuser;
        end
    end

    assign m_tdata  = main_tdata;
    assign m_tkeep  = main_tkeep;
    assign m_tvalid = main_tvalid;
    assign m_tlast  = main_tlast;
    assign m_tuser  = main_tuser;

endmodule

// ==== verilog/axis_rate_limit_top.sv ====
`timescale 1ns/1ps

// rate limiter subsystem
// config registers, limiter and output skid register
module axis_rate_limit_top #(
    parameter int  DATA_WIDTH = axis_pkg::AXIS_DATA_WIDTH,
    localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  rst,

    // input stream
    input  logic [DATA_WIDTH-1:0] s_axis_tdata,
    input  logic [KEEP_WIDTH-1:0] s_axis_tkeep,
    input  logic                  s_axis_tvalid,
    output logic                  s_axis_tready,
    input  logic                  s_axis_tlast,
    input  logic                  s_axis_tuser,

    // output stream
    output logic [DATA_WIDTH-1:0] m_axis_tdata,
    output logic [KEEP_WIDTH-1:0] m_axis_tkeep,
    output logic                  m_axis_tvalid,
    input  logic                  m_axis_tready,
    output logic                  m_axis_tlast,
    output logic                  m_axis_tuser,

    // config port
    input  logic                  cfg_we,
    input  rate_pkg::cfg_addr_t   cfg_addr,
    input  rate_pkg::rate_t       cfg_wdata,
    output rate_pkg::rate_t       cfg_rdata
);

    import rate_pkg::*;

    rate_t rate_num;
    rate_t rate_denom;
    logic  rate_by_frame;
    logic  ready_early;

    // limiter to skid register
    axis_if #(.DATA_WIDTH(DATA_WIDTH)) lim_to_skid ();

    rate_cfg_regs i_rate_cfg_regs (
        .clk           (clk),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .rate_num      (rate_num),
        .rate_denom    (rate_denom),
        .rate_by_frame (rate_by_frame)
    );

    axis_rate_limit #(.DATA_WIDTH(DATA_WIDTH)) i_axis_rate_limit (
        .clk           (clk),
        .rst           (rst),
        .s_tdata       (s_axis_tdata),
        .s_tkeep       (s_axis_tkeep),
        .s_tvalid      (s_axis_tvalid),
        .s_tready      (s_axis_tready),
        .s_tlast       (s_axis_tlast),
        .s_tuser       (s_axis_tuser),
        .m             (lim_to_skid.source),
        .ready_early   (ready_early),
        .rate_num      (rate_num),
        .rate_denom    (rate_denom),
        .rate_by_frame (rate_by_frame)
    );

    axis_skid_reg #(.DATA_WIDTH(DATA_WIDTH)) i_axis_skid_reg (
        .clk         (clk),
        .rst         (rst),
        .s           (lim_to_skid.sink),
        .ready_early (ready_early),
        .m_tdata     (m_axis_tdata),
        .m_tkeep     (m_axis_tkeep),
        .m_tvalid    (m_axis_tvalid),
        .m_tready    (m_axis_tready),
        .m_tlast     (m_axis_tlast),
        .m_tuser     (m_axis_tuser)
    );

endmodule

// ==== tb/rate_limit_checker.sv ====
`timescale 1ns/1ps

// watches the top-level ports and compares against the beat rule
module rate_limit_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 s_axis_tvalid,
    input logic                 s_axis_tready,
    input logic                 s_axis_tlast,
    input axis_pkg::axis_data_t m_axis_tdata,
    input axis_pkg::axis_keep_t m_axis_tkeep,
    input logic                 m_axis_tvalid,
    input logic                 m_axis_tready,
    input logic                 m_axis_tlast,
    input logic                 m_axis_tuser
);

    import axis_pkg::*;

    localparam int frame_len = 5;

    int errors = 0;
    int error_mark = 0;
    int tests = 0;
    int win_start = 0;
    logic frame_chk = 1'b0;

    // output and input beat counters
    int out_k;
    int in_total;
    logic rst_prev;
    logic in_frame;
    logic out_in_frame;

    // last output beat seen while the sink stalled
    logic       stall_prev;
    axis_data_t hold_data;
    axis_keep_t hold_keep;
    logic       hold_last;
    logic       hold_user;

    // expected beat k, every frame_len beats a frame ends
    function automatic logic ref_last(int k);
        return (k % frame_len) == frame_len - 1;
    endfunction

    function automatic axis_data_t ref_data(int k);
        logic [31:0] kv;
        kv = k[31:0];
        return {~kv, kv};
    endfunction

    // full keep, the last beat of a frame keeps k%8+1 bytes
    function automatic axis_keep_t ref_keep(int k);
        axis_keep_t keep;
        if (!ref_last(k)) begin
            return '1;
        end
        keep = '0;
        for (int i = 0; i <= k % 8; i++) begin
            keep[i] = 1'b1;
        end
        return keep;
    endfunction

    // user flag on the last beat of every seventh frame
    function automatic logic ref_user(int k);
        return ref_last(k) && ((k / frame_len) % 7 == 6);
    endfunction

    task automatic check_eq(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic report_test(string name);
        tests++;
        if (errors == error_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - error_mark);
        end
        error_mark = errors;
    endtask

    task automatic start_window();
        win_start = in_total;
    endtask

    // accepted beats over the window against cycles*num/denom
    task automatic check_window(string name, int cycles, int num, int denom, int tol);
        int exp;
        int got;
        int diff;
        exp  = cycles * num / denom;
        got  = in_total - win_start;
        diff = (got > exp) ? got - exp : exp - got;
        if (diff > tol) begin
            errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, got);
        end else begin
            $display("  %s: %0d beats in %0d cycles, target %0d", name, got, cycles, exp);
        end
    endtask

    task automatic set_frame_check(logic en);
        frame_chk = en;
    endtask

    always @(posedge clk) begin
        rst_prev <= rst;
        if (rst || rst_prev) begin
            // both sides stay closed through reset and the edge after
            check_eq("m_axis_tvalid", 64'(0), 64'(m_axis_tvalid));
            check_eq("s_axis_tready", 64'(0), 64'(s_axis_tready));
            out_k        <= 0;
            in_total     <= 0;
            in_frame     <= 1'b0;
            out_in_frame <= 1'b0;
            stall_prev   <= 1'b0;
        end else begin
            // a stalled beat must not change
            if (stall_prev) begin
                check_eq("m_axis_tvalid", 64'(1), 64'(m_axis_tvalid));
                check_eq("m_axis_tdata", hold_data, m_axis_tdata);
                check_eq("m_axis_tkeep", 64'(hold_keep), 64'(m_axis_tkeep));
                check_eq("m_axis_tlast", 64'(hold_last), 64'(m_axis_tlast));
                check_eq("m_axis_tuser", 64'(hold_user), 64'(m_axis_tuser));
            end
            stall_prev <= m_axis_tvalid && !m_axis_tready;
            hold_data  <= m_axis_tdata;
            hold_keep  <= m_axis_tkeep;
            hold_last  <= m_axis_tlast;
            hold_user  <= m_axis_tuser;

            if (s_axis_tvalid && s_axis_tready) begin
                in_total <= in_total + 1;
                in_frame <= !s_axis_tlast;
            end

            // frame mode, no gap until tlast
            if (frame_chk && in_frame && s_axis_tvalid && !s_axis_tready) begin
                report_error("input stalled inside a frame");
            end
            if (frame_chk && out_in_frame && !m_axis_tvalid) begin
                report_error("output gap inside a frame");
            end

            if (m_axis_tvalid && m_axis_tready) begin
                if (out_k >= in_total) begin
                    report_error("output beat without a matching input beat");
                end
                check_eq("m_axis_tdata", ref_data(out_k), m_axis_tdata);
                check_eq("m_axis_tkeep", 64'(ref_keep(out_k)), 64'(m_axis_tkeep));
                check_eq("m_axis_tlast", 64'(ref_last(out_k)), 64'(m_axis_tlast));
                check_eq("m_axis_tuser", 64'(ref_user(out_k)), 64'(m_axis_tuser));
                out_k        <= out_k + 1;
                out_in_frame <= !m_axis_tlast;
            end
        end
    end

endmodule

// ==== tb/tb_axis_rate_limit.sv ====
`timescale 1ns/1ps

// testbench top for the rate limiter subsystem
module tb_axis_rate_limit;

    import axis_pkg::*;
    import rate_pkg::*;

    localparam int frame_len   = 5;
    localparam int window      = 400;
    localparam int settle      = 20;
    localparam int full_beats  = 120;
    localparam int bp_cycles   = 300;
    // three rate windows, the full rate and back-pressure runs
    // plus room for config writes and drains
    localparam int test_cycles = 3 * (settle + window) + full_beats + bp_cycles + 200;

    logic       clk;
    logic       rst;
    axis_data_t s_axis_tdata = '0;
    axis_keep_t s_axis_tkeep = '0;
    logic       s_axis_tvalid = 1'b0;
    logic       s_axis_tready;
    logic       s_axis_tlast = 1'b0;
    logic       s_axis_tuser = 1'b0;
    axis_data_t m_axis_tdata;
    axis_keep_t m_axis_tkeep;
    logic       m_axis_tvalid;
    logic       m_axis_tready = 1'b0;
    logic       m_axis_tlast;
    logic       m_axis_tuser;
    logic       cfg_we;
    cfg_addr_t  cfg_addr;
    rate_t      cfg_wdata;
    rate_t      cfg_rdata;

    // source enable and random sink ready
    logic src_en;
    logic rand_ready;
    int   in_k;
    int   seed = 36;

    axis_rate_limit_top #(.DATA_WIDTH(AXIS_DATA_WIDTH)) i_axis_rate_limit_top (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata)
    );

    rate_limit_checker i_checker (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // stimulus side of the beat rule
    function automatic logic beat_last(int k);
        return (k % frame_len) == frame_len - 1;
    endfunction

    function automatic axis_keep_t beat_keep(int k);
        axis_keep_t keep;
        keep = '0;
        for (int i = 0; i < 8; i++) begin
            keep[i] = !beat_last(k) || (i <= k % 8);
        end
        return keep;
    endfunction

    // source holds a beat until it moves
    // sink ready random or held high
    always @(posedge clk) begin : drive
        int nk;
        if (rst) begin
            in_k          <= 0;
            s_axis_tvalid <= 1'b0;
            m_axis_tready <= 1'b0;
        end else begin
            nk = in_k + ((s_axis_tvalid && s_axis_tready) ? 1 : 0);
            in_k          <= nk;
            s_axis_tvalid <= src_en || (s_axis_tvalid && !s_axis_tready);
            s_axis_tdata  <= {~nk[31:0], nk[31:0]};
            s_axis_tkeep  <= beat_keep(nk);
            s_axis_tlast  <= beat_last(nk);
            s_axis_tuser  <= beat_last(nk) && ((nk / frame_len) % 7 == 6);
            m_axis_tready <= rand_ready ? 1'($random(seed)) : 1'b1;
        end
    end

    task automatic cfg_write(cfg_addr_t addr, rate_t data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic read_check(cfg_addr_t addr, rate_t exp);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        i_checker.check_eq("cfg_rdata", 64'(exp), 64'(cfg_rdata));
    endtask

    task automatic set_rate(rate_t num, rate_t denom, logic by_frame);
        cfg_write(CFG_ADDR_NUM, num);
        cfg_write(CFG_ADDR_DENOM, denom);
        cfg_write(CFG_ADDR_MODE, rate_t'(by_frame));
    endtask

    task automatic wait_beats(int n);
        int target;
        int waited;
        target = i_checker.in_total + n;
        waited = 0;
        while (i_checker.in_total < target && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 1000) begin
            i_checker.report_error("source beats were not accepted in time");
        end
    endtask

    // stop the source, open the sink and wait until every beat is out
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        src_en     <= 1'b0;
        rand_ready <= 1'b0;
        @(negedge clk);
        while ((s_axis_tvalid || m_axis_tvalid) && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 1000) begin
            i_checker.report_error("pipeline did not drain");
        end else begin
            i_checker.check_eq("beat count", 64'(i_checker.in_total), 64'(i_checker.out_k));
        end
    endtask

    task automatic run_window(string name, int num, int denom, int tol, logic frames);
        @(posedge clk);
        src_en <= 1'b1;
        repeat (settle) @(posedge clk);
        @(negedge clk);
        i_checker.set_frame_check(frames);
        i_checker.start_window();
        repeat (window) @(negedge clk);
        i_checker.set_frame_check(1'b0);
        i_checker.check_window(name, window, num, denom, tol);
    endtask

    initial begin
        rst        <= 1'b1;
        cfg_we     <= 1'b0;
        cfg_addr   <= '0;
        cfg_wdata  <= '0;
        src_en     <= 1'b0;
        rand_ready <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        read_check(CFG_ADDR_NUM, 8'd1);
        read_check(CFG_ADDR_DENOM, 8'd1);
        read_check(CFG_ADDR_MODE, 8'd0);
        i_checker.report_test("reset");

        cfg_write(CFG_ADDR_NUM, 8'd5);
        cfg_write(CFG_ADDR_DENOM, 8'd9);
        cfg_write(CFG_ADDR_MODE, 8'd1);
        read_check(CFG_ADDR_NUM, 8'd5);
        read_check(CFG_ADDR_DENOM, 8'd9);
        read_check(CFG_ADDR_MODE, 8'd1);
        // address 3 is not mapped
        cfg_write(2'd3, 8'haa);
        read_check(2'd3, 8'd0);
        i_checker.report_test("config");

        set_rate(8'd1, 8'd1, 1'b0);
        @(posedge clk);
        src_en <= 1'b1;
        wait_beats(full_beats);
        drain();
        i_checker.report_test("full rate");

        set_rate(8'd1, 8'd4, 1'b0);
        run_window("rate 1/4", 1, 4, 3, 1'b0);
        drain();
        set_rate(8'd3, 8'd5, 1'b0);
        run_window("rate 3/5", 3, 5, 3, 1'b0);
        drain();
        i_checker.report_test("rate limit");

        // frame mode with the tolerance widened by one frame
        set_rate(8'd1, 8'd3, 1'b1);
        run_window("frame rate 1/3", 1, 3, 3 + frame_len, 1'b1);
        drain();
        i_checker.report_test("frame mode");

        set_rate(8'd1, 8'd2, 1'b0);
        @(posedge clk);
        rand_ready <= 1'b1;
        src_en     <= 1'b1;
        repeat (bp_cycles) @(posedge clk);
        drain();
        i_checker.report_test("back-pressure");

        $display("tests run %0d, errors %0d", i_checker.tests, i_checker.errors);
        if (i_checker.errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // cycle budget times four
    initial begin
        #(test_cycles * 4 * 8);
        $display("watchdog: the run did not finish within its cycle budget");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== build.f ====
verilog/axis_pkg.sv
verilog/rate_pkg.sv
verilog/axis_if.sv
verilog/rate_cfg_regs.sv
verilog/axis_rate_limit.sv
verilog/axis_skid_reg.sv
verilog/axis_rate_limit_top.sv
tb/rate_limit_checker.sv
tb/tb_axis_rate_limit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rate limiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f build.f --top-module tb_axis_rate_limit -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
